// File: source/obstaclePkg.sv
package obstaclePkg;

	typedef enum logic [2:0] {Large1, Large2, Large3, Small1, Small2, Small3} spriteType;

	// Idle = 0 so the status field reads 0 after reset
	typedef enum logic [1:0] {Idle, Pick, Scroll} fsmState;

	localparam int addrWidth = 18;
	localparam int startX = 640;
	localparam int stepSize = 2;
	localparam int groundLarge = 320;	// top row of the tall cacti
	localparam int groundSmall = 350;

	localparam logic [3:0] ctrlAddr = 4'h0;
	localparam logic [3:0] speedAddr = 4'h4;
	localparam logic [3:0] seedAddr = 4'h8;
	localparam logic [3:0] statusAddr = 4'hC;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} point;

	typedef struct packed {
		spriteType kind;
		logic signed [10:0] posX;	// goes negative while leaving on the left
		logic [9:0] posY;
	} obstacleState;

	typedef struct packed {
		logic [addrWidth-1:0] base;
		logic [7:0] width;
		logic [6:0] height;
	} spriteInfo;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	// sprites are packed back to back in one memory
	function automatic spriteInfo spriteLookup(spriteType kind);
		spriteInfo info;
		case (kind)
			Large1: info = '{base: 18'd0, width: 8'd50, height: 7'd100};
			Large2: info = '{base: 18'd5000, width: 8'd100, height: 7'd100};
			Large3: info = '{base: 18'd15000, width: 8'd150, height: 7'd100};
			Small1: info = '{base: 18'd30000, width: 8'd36, height: 7'd70};
			Small2: info = '{base: 18'd32520, width: 8'd68, height: 7'd70};
			default: info = '{base: 18'd37280, width: 8'd102, height: 7'd70};
		endcase
		return info;
	endfunction

endpackage

// File: source/lfsr.sv
`timescale 1ns/1ps

module lfsr #(
	parameter int lfsrWidth = 6
) (
	input logic frame_Clk,
	input logic Reset,
	input logic seedLoad,
	input logic [lfsrWidth-1:0] seedValue,
	output logic [lfsrWidth-1:0] randNum
);

	// x^6 + x^5 + 1 for the default width
	localparam logic [lfsrWidth-1:0] taps = {2'b11, {(lfsrWidth-2){1'b0}}};

	logic [lfsrWidth-1:0] shiftReg;

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			shiftReg <= lfsrWidth'(1);
		else if (seedLoad)
			shiftReg <= (seedValue == '0) ? lfsrWidth'(1) : seedValue;	// zero would lock up
		else
			shiftReg <= (shiftReg >> 1) ^ (taps & {lfsrWidth{shiftReg[0]}});
	end

	assign randNum = shiftReg;

	// a Galois register never leaves the nonzero cycle once seeded
	neverZero: assert property (@(posedge frame_Clk) disable iff (Reset)
		randNum != '0);

endmodule

// File: source/scrollTimer.sv
`timescale 1ns/1ps

module scrollTimer #(
	parameter int speedWidth = 8
) (
	input logic frame_Clk,
	input logic Reset,
	input logic enable,
	input logic [speedWidth-1:0] speed,
	output logic step
);

	logic [speedWidth-1:0] frameCount;
	logic wrap;

	// >= so a lowered speed never lets the count run away
	assign wrap = (frameCount >= speed);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			frameCount <= '0;
		else if (!enable)
			frameCount <= '0;	// held while stopped
		else if (wrap)
			frameCount <= '0;
		else
			frameCount <= frameCount + 1'b1;
	end

	// one pulse per speed+1 frames
	assign step = enable && wrap;

	// back to back steps only make sense at the fastest setting
	singlePulse: assert property (@(posedge frame_Clk) disable iff (Reset)
		step |=> (!step || speed == '0));

endmodule

// File: source/obstacleFsm.sv
`timescale 1ns/1ps

module obstacleFsm #(
	parameter int lfsrWidth = 6
) (
	input logic frame_Clk,
	input logic Reset,
	input logic enable,
	input logic step,
	input logic [lfsrWidth-1:0] randNum,
	output obstaclePkg::obstacleState obstacle,
	output obstaclePkg::fsmState state
);

	obstaclePkg::fsmState stateQ;
	obstaclePkg::spriteType pickKind;
	obstaclePkg::spriteInfo info;
	logic signed [10:0] leftLimit;
	logic [9:0] groundRow;

	// 2 top bits pick the quarter, the next bit splits the odd quarters
	always_comb
	begin
		unique casez (randNum[lfsrWidth-1 -: 3])
			3'b00?: pickKind = obstaclePkg::Large1;	// 1/4
			3'b010: pickKind = obstaclePkg::Large2;
			3'b011: pickKind = obstaclePkg::Large3;
			3'b10?: pickKind = obstaclePkg::Small1;	// 1/4
			3'b110: pickKind = obstaclePkg::Small2;
			default: pickKind = obstaclePkg::Small3;
		endcase
	end

	assign groundRow = (pickKind inside {obstaclePkg::Large1, obstaclePkg::Large2,
		obstaclePkg::Large3}) ? 10'(obstaclePkg::groundLarge) : 10'(obstaclePkg::groundSmall);

	assign info = obstaclePkg::spriteLookup(obstacle.kind);
	assign leftLimit = -$signed({3'b000, info.width});	// fully off screen
	assign state = stateQ;

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			stateQ <= obstaclePkg::Idle;
			obstacle.kind <= obstaclePkg::Large1;
			obstacle.posX <= 11'(obstaclePkg::startX);
			obstacle.posY <= 10'(obstaclePkg::groundLarge);
		end
		else if (!enable)
		begin
			stateQ <= obstaclePkg::Idle;
			obstacle.posX <= 11'(obstaclePkg::startX);
		end
		else
		begin
			case (stateQ)
				obstaclePkg::Idle:
					stateQ <= obstaclePkg::Pick;
				obstaclePkg::Pick:
				begin
					obstacle.kind <= pickKind;
					obstacle.posY <= groundRow;
					stateQ <= obstaclePkg::Scroll;
				end
				obstaclePkg::Scroll:
				begin
					if (step)
					begin
						if (obstacle.posX == leftLimit)
						begin
							// respawn at the right edge with a fresh type
							obstacle.posX <= 11'(obstaclePkg::startX);
							stateQ <= obstaclePkg::Pick;
						end
						else
							obstacle.posX <= obstacle.posX - 11'(obstaclePkg::stepSize);
					end
				end
				default:
					stateQ <= obstaclePkg::Idle;
			endcase
		end
	end

	inRange: assert property (@(posedge frame_Clk) disable iff (Reset)
		(stateQ == obstaclePkg::Scroll) |->
			(obstacle.posX >= leftLimit && obstacle.posX <= obstaclePkg::startX));

endmodule

// File: source/spriteWindow.sv
`timescale 1ns/1ps

module spriteWindow (
	input obstaclePkg::obstacleState obstacle,
	input obstaclePkg::point pos,
	output logic hit,
	output logic [obstaclePkg::addrWidth-1:0] address
);

	obstaclePkg::spriteInfo info;
	logic signed [11:0] dx;
	logic signed [11:0] dy;
	logic inX;
	logic inY;

	assign info = obstaclePkg::spriteLookup(obstacle.kind);

	// offsets from the sprite's top left corner, signed so negative posX works
	always_comb
	begin
		dx = $signed({2'b00, pos.x}) - $signed({obstacle.posX[10], obstacle.posX});
		dy = $signed({2'b00, pos.y}) - $signed({2'b00, obstacle.posY});
	end

	// dx >= 0 also covers a left edge that already scrolled past 0
	assign inX = (dx >= 0) && (dx < $signed({4'b0000, info.width}));
	assign inY = (dy >= 0) && (dy < $signed({5'b00000, info.height}));
	assign hit = inX && inY;

	// row major inside the sprite
	always_comb
	begin
		if (hit)
			address = info.base
				+ obstaclePkg::addrWidth'(dy[6:0] * info.width)
				+ obstaclePkg::addrWidth'(dx[7:0]);
		else
			address = '0;
	end

endmodule

// File: source/apbConfig.sv
`timescale 1ns/1ps

module apbConfig #(
	parameter int speedWidth = 8,
	parameter int lfsrWidth = 6
) (
	input logic frame_Clk,
	input logic Reset,
	input obstaclePkg::apbReq req,
	output obstaclePkg::apbRsp rsp,
	input obstaclePkg::obstacleState obstacle,
	input obstaclePkg::fsmState state,
	output logic enable,
	output logic [speedWidth-1:0] speed,
	output logic seedLoad,
	output logic [lfsrWidth-1:0] seedValue
);

	logic access;
	logic writeOk;
	logic mapped;
	logic [31:0] statusWord;

	assign access = req.psel && req.penable;
	assign mapped = req.paddr inside {obstaclePkg::ctrlAddr, obstaclePkg::speedAddr,
		obstaclePkg::seedAddr, obstaclePkg::statusAddr};
	assign writeOk = access && req.pwrite && mapped && (req.paddr != obstaclePkg::statusAddr);

	// state, sign extended posX, kind
	assign statusWord = {4'b0000, 4'(state), {5{obstacle.posX[10]}}, obstacle.posX,
		5'b00000, obstacle.kind};

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			enable <= 1'b0;
			speed <= '0;
			seedValue <= '0;
			seedLoad <= 1'b0;
		end
		else
		begin
			seedLoad <= writeOk && (req.paddr == obstaclePkg::seedAddr);	// one cycle only
			if (writeOk && req.paddr == obstaclePkg::ctrlAddr)
				enable <= req.pwdata[0];
			if (writeOk && req.paddr == obstaclePkg::speedAddr)
				speed <= req.pwdata[speedWidth-1:0];
			if (writeOk && req.paddr == obstaclePkg::seedAddr)
				seedValue <= req.pwdata[lfsrWidth-1:0];
		end
	end

	always_comb
	begin
		case (req.paddr)
			obstaclePkg::ctrlAddr: rsp.prdata = {31'd0, enable};
			obstaclePkg::speedAddr: rsp.prdata = 32'(speed);
			obstaclePkg::seedAddr: rsp.prdata = 32'(seedValue);
			obstaclePkg::statusAddr: rsp.prdata = statusWord;
			default: rsp.prdata = '0;
		endcase
	end

	assign rsp.pready = 1'b1;	// no wait states
	// status is read only, holes in the map fault
	assign rsp.pslverr = access && (!mapped || (req.pwrite && req.paddr == obstaclePkg::statusAddr));

	enableNeedsSel: assert property (@(posedge frame_Clk) disable iff (Reset)
		req.penable |-> req.psel);

endmodule

// File: source/obstacleTop.sv
`timescale 1ns/1ps

module obstacleTop #(
	parameter int lfsrWidth = 6,
	parameter int speedWidth = 8
) (
	input logic frame_Clk,
	input logic Reset,
	input obstaclePkg::apbReq req,
	output obstaclePkg::apbRsp rsp,
	input obstaclePkg::point writePos,
	input obstaclePkg::point drawPos,
	output logic writeHit,
	output logic drawHit,
	output logic [obstaclePkg::addrWidth-1:0] address
);

	logic enable;
	logic [speedWidth-1:0] speed;
	logic seedLoad;
	logic [lfsrWidth-1:0] seedValue;
	logic [lfsrWidth-1:0] randNum;
	logic step;
	obstaclePkg::obstacleState obstacle;
	obstaclePkg::fsmState state;

	apbConfig #(.speedWidth(speedWidth), .lfsrWidth(lfsrWidth)) cfg (
		.frame_Clk, .Reset, .req, .rsp, .obstacle, .state,
		.enable, .speed, .seedLoad, .seedValue);

	lfsr #(.lfsrWidth(lfsrWidth)) rng (
		.frame_Clk, .Reset, .seedLoad, .seedValue, .randNum);

	scrollTimer #(.speedWidth(speedWidth)) timer (
		.frame_Clk, .Reset, .enable, .speed, .step);

	obstacleFsm #(.lfsrWidth(lfsrWidth)) fsm (
		.frame_Clk, .Reset, .enable, .step, .randNum, .obstacle, .state);

	spriteWindow writeWin (.obstacle, .pos(writePos), .hit(writeHit), .address);

	// draw side needs only the hit
	spriteWindow drawWin (.obstacle, .pos(drawPos), .hit(drawHit), .address());

endmodule

// File: dv/obstacleTb.sv
`timescale 1ns/1ps

module obstacleTb;

	localparam int screenW = 640;
	localparam int idleCode = 0;
	localparam int scrollCode = 2;
	localparam int scrollSpeed = 7;	// 8 frames per step while watching a full pass
	localparam int numRows = 8;
	localparam int randPoints = 20;
	// widest sprite crossing the whole screen at scrollSpeed
	localparam int longestScroll = ((screenW + 150) / 2 + 2) * (scrollSpeed + 1);
	localparam int timeoutCycles = (numRows + 4) * longestScroll;

	localparam int baseTab[6] = '{0, 5000, 15000, 30000, 32520, 37280};
	localparam int widthTab[6] = '{50, 100, 150, 36, 68, 102};
	localparam int heightTab[6] = '{100, 100, 100, 70, 70, 70};

	// write point relative to the sprite corner, plus width or height when flagged
	typedef struct packed {
		int dxAdd;
		logic addWidth;
		int dyAdd;
		logic addHeight;
		logic expHit;
	} pointCase;

	localparam pointCase pointTable[numRows] = '{
		'{0, 1'b0, 0, 1'b0, 1'b1},	// top left corner
		'{-1, 1'b1, -1, 1'b1, 1'b1},	// bottom right corner
		'{-1, 1'b0, 0, 1'b0, 1'b0},
		'{0, 1'b1, 0, 1'b0, 1'b0},	// one past the right edge
		'{0, 1'b0, -1, 1'b0, 1'b0},
		'{0, 1'b0, 0, 1'b1, 1'b0},
		'{9, 1'b0, 33, 1'b0, 1'b1},
		'{-1, 1'b1, 0, 1'b1, 1'b0}
	};

	logic frame_Clk;
	logic Reset;
	obstaclePkg::apbReq req;
	obstaclePkg::apbRsp rsp;
	obstaclePkg::point writePos;
	obstaclePkg::point drawPos;
	logic writeHit;
	logic drawHit;
	logic [obstaclePkg::addrWidth-1:0] address;
	logic [31:0] rngState = 32'hd1a3_8191;
	int errCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int errAtStart = 0;
	int cycleCount = 0;

	obstacleTop UUT (.frame_Clk, .Reset, .req, .rsp, .writePos, .drawPos,
		.writeHit, .drawHit, .address);

	initial
	begin
		frame_Clk = 1'b0;
		forever #50 frame_Clk = ~frame_Clk;
	end

	initial
	begin
		while (cycleCount < timeoutCycles)
		begin
			@(posedge frame_Clk);
			cycleCount++;
		end
		$display("Timeout: no result after %0d clock cycles", timeoutCycles);
		$display("Simulation failed");
		$finish;
	end

	function automatic int takeBits(input int n);
		int val = 0;
		for (int i = 0; i < n; i++)
		begin
			rngState = rngState[0] ? ((rngState >> 1) ^ 32'h8020_0003) : (rngState >> 1);
			val = (val << 1) | int'(rngState[0]);
		end
		return val;
	endfunction

	// window reference, posY follows the ground rule of the kind
	function automatic int modelAddr(input int kind, input int posX, input int x, input int y,
		output logic hit);
		int dx = x - posX;
		int dy = y - ((kind < 3) ? 320 : 350);
		hit = (dx >= 0) && (dx < widthTab[kind]) && (dy >= 0) && (dy < heightTab[kind]);
		return hit ? baseTab[kind] + dy * widthTab[kind] + dx : 0;
	endfunction

	task automatic checkEq(input string msg, input int got, input int exp);
		if (got != exp)
		begin
			errCount++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, msg, got, exp);
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errCount != errAtStart)
			failedTests++;
		$display("test %0d %s finished with %0d mismatches", testCount, name,
			errCount - errAtStart);
		errAtStart = errCount;
	endtask

	// setup cycle, access cycle, response taken in the middle of the access
	task automatic apbAccess(input logic write, input logic [3:0] addr, input int wdata,
		output int rdata, output int err);
		@(posedge frame_Clk);
		req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge frame_Clk);
		req.penable <= 1'b1;
		@(negedge frame_Clk);
		rdata = int'(rsp.prdata);
		err = int'(rsp.pslverr);
		checkEq("pready in access cycle", int'(rsp.pready), 1);	// no wait states
		@(posedge frame_Clk);
		req <= '0;
	endtask

	task automatic regWrite(input logic [3:0] addr, input int data);
		int rd, err;
		apbAccess(1'b1, addr, data, rd, err);
		checkEq("pslverr on write", err, 0);
	endtask

	task automatic regCheck(input logic [3:0] addr, input int exp, input string name);
		int rd, err;
		apbAccess(1'b0, addr, 0, rd, err);
		checkEq({name, " pslverr"}, err, 0);
		checkEq(name, rd, exp);
	endtask

	task automatic readStatus(output int kind, output int posX, output int state);
		int rd, err;
		apbAccess(1'b0, obstaclePkg::statusAddr, 0, rd, err);
		kind = rd & 7;
		posX = int'($signed(rd[23:8]));
		state = (rd >> 24) & 15;
	endtask

	task automatic visibleMiss();
		@(posedge frame_Clk);
		writePos <= '{x: 10'(takeBits(10) % screenW), y: 10'(takeBits(9) % 480)};
		drawPos <= '{x: 10'(takeBits(10) % screenW), y: 10'(takeBits(9) % 480)};
		@(negedge frame_Clk);
		checkEq("writeHit on screen", int'(writeHit), 0);
		checkEq("drawHit on screen", int'(drawHit), 0);
	endtask

	// row < 0 gives a random write point, the draw point is always random near the sprite
	task automatic checkPoint(input int row);
		int k, p, s, k2, p2, wx, wy, dx, dy, gotAddr, expAddr;
		logic gotWrite, gotDraw, expWrite, expDraw;
		int tries = 0;
		do
		begin
			readStatus(k, p, s);
			wx = p - 20 + takeBits(9) % (widthTab[k] + 40);
			wy = ((k < 3) ? 320 : 350) - 20 + takeBits(8) % (heightTab[k] + 40);
			dx = p - 20 + takeBits(9) % (widthTab[k] + 40);
			dy = ((k < 3) ? 320 : 350) - 20 + takeBits(8) % (heightTab[k] + 40);
			if (row >= 0)
			begin
				wx = p + pointTable[row].dxAdd + (pointTable[row].addWidth ? widthTab[k] : 0);
				wy = ((k < 3) ? 320 : 350) + pointTable[row].dyAdd
					+ (pointTable[row].addHeight ? heightTab[k] : 0);
			end
			@(posedge frame_Clk);
			writePos <= '{x: 10'(wx), y: 10'(wy)};
			drawPos <= '{x: 10'(dx), y: 10'(dy)};
			@(negedge frame_Clk);
			gotWrite = writeHit;
			gotDraw = drawHit;
			gotAddr = int'(address);
			readStatus(k2, p2, s);	// obstacle must not have moved meanwhile
			tries++;
		end while ((k2 != k || p2 != p) && tries < 4);
		expAddr = modelAddr(k, p, wx, wy, expWrite);
		void'(modelAddr(k, p, dx, dy, expDraw));
		if (row >= 0)
			checkEq($sformatf("row %0d hit", row), int'(gotWrite), int'(pointTable[row].expHit));
		checkEq("writeHit", int'(gotWrite), int'(expWrite));
		checkEq("drawHit", int'(gotDraw), int'(expDraw));
		checkEq("address", gotAddr, expAddr);
		if (k2 != k || p2 != p)
		begin
			errCount++;
			$display("obstacle moved during every try of a point check");
		end
	endtask

	initial
	begin
		int kind, posX, prevX, prevKind, state, rd, err;
		req = '0;
		writePos = '0;
		drawPos = '0;
		Reset = 1'b1;
		repeat (5) @(posedge frame_Clk);
		Reset <= 1'b0;

		readStatus(kind, posX, state);
		checkEq("kind after reset", kind, 0);
		checkEq("posX after reset", posX, screenW);
		checkEq("state after reset", state, idleCode);
		regCheck(obstaclePkg::ctrlAddr, 0, "ctrl after reset");
		regCheck(obstaclePkg::speedAddr, 0, "speed after reset");
		for (int i = 0; i < 6; i++)
			visibleMiss();
		endTest("reset values");

		regWrite(obstaclePkg::speedAddr, 32'h5a);
		regCheck(obstaclePkg::speedAddr, 32'h5a, "speed readback");
		regWrite(obstaclePkg::ctrlAddr, 1);
		regCheck(obstaclePkg::ctrlAddr, 1, "ctrl readback");
		regWrite(obstaclePkg::ctrlAddr, 0);
		regCheck(obstaclePkg::ctrlAddr, 0, "ctrl cleared");
		apbAccess(1'b1, obstaclePkg::statusAddr, 32'h0000_00ff, rd, err);
		checkEq("pslverr on status write", err, 1);
		apbAccess(1'b0, 4'h2, 0, rd, err);
		checkEq("pslverr on unmapped read", err, 1);
		apbAccess(1'b1, 4'h6, 1, rd, err);
		checkEq("pslverr on unmapped write", err, 1);
		regCheck(obstaclePkg::speedAddr, 32'h5a, "speed after errors");
		regCheck(obstaclePkg::ctrlAddr, 0, "ctrl after errors");
		endTest("apb registers");

		regWrite(obstaclePkg::seedAddr, 32'h2b);
		regWrite(obstaclePkg::speedAddr, 3);
		repeat (40) @(posedge frame_Clk);
		readStatus(kind, posX, state);
		checkEq("posX while disabled", posX, screenW);
		checkEq("state while disabled", state, idleCode);
		regCheck(obstaclePkg::seedAddr, 32'h2b, "seed readback");
		regCheck(obstaclePkg::speedAddr, 3, "speed while disabled");
		for (int i = 0; i < 6; i++)
			visibleMiss();
		endTest("disabled hold");

		regWrite(obstaclePkg::speedAddr, 0);
		regWrite(obstaclePkg::ctrlAddr, 1);
		posX = screenW;
		while (posX > 400)
			readStatus(kind, posX, state);
		regWrite(obstaclePkg::speedAddr, 255);	// nearly still while probing
		for (int i = 0; i < numRows + randPoints; i++)
			checkPoint((i < numRows) ? i : -1);
		endTest("hit and address");

		regWrite(obstaclePkg::speedAddr, scrollSpeed);
		readStatus(prevKind, prevX, state);
		readStatus(kind, posX, state);
		while (posX != screenW || prevX == screenW)
		begin
			checkEq("posX step parity", (prevX - posX) % 2, 0);
			if (posX > prevX)
				checkEq("posX moved right", posX, prevX);
			prevX = posX;
			prevKind = kind;
			readStatus(kind, posX, state);
		end
		checkEq("last posX before respawn", prevX, -widthTab[prevKind]);
		while (state != scrollCode)
			readStatus(kind, posX, state);
		regWrite(obstaclePkg::speedAddr, 255);
		if (kind > 5)
		begin
			errCount++;
			$display("respawned obstacle has kind %0d, which is no sprite type", kind);
		end
		else
		begin
			checkPoint(0);	// top row sits on the ground line
			checkPoint(4);
		end
		regWrite(obstaclePkg::speedAddr, 0);	// moving again so the stop has to pull it back
		readStatus(kind, posX, state);
		while (posX == screenW)
			readStatus(kind, posX, state);
		regWrite(obstaclePkg::ctrlAddr, 0);
		readStatus(kind, posX, state);
		checkEq("posX after stop", posX, screenW);
		endTest("scroll and respawn");

		$display("tests run %0d, tests failed %0d, mismatches %0d", testCount, failedTests,
			errCount);
		if (errCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: build.f
source/obstaclePkg.sv
source/lfsr.sv
source/scrollTimer.sv
source/obstacleFsm.sv
source/spriteWindow.sv
source/apbConfig.sv
source/obstacleTop.sv
dv/obstacleTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -f build.f --top-module obstacleTb -o obstacleSim \
	&& ./obj_dir/obstacleSim; } > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
